//--- all.f
source/cache_pkg.sv
source/cache_array.sv
source/cache_data_array.sv
source/cache_datapath.sv
source/cache_control.sv
source/cache_top.sv
verif/pmem_model.sv
verif/tb_cache_top.sv

//--- run_sim.sh
#!/bin/sh
# builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_cache_top \
    --Mdir obj_dir -o tb_cache_top
build_status=$?
if [ $build_status -ne 0 ]
then
    echo "build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_cache_top > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]
then
    echo "simulation returned status $run_status"
    exit 1
fi

if grep -q "TB PASSED" sim.log
then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

//--- verif/cache_patterns.txt
# op address byte_enable wdata_word expected_rdata_word mem_reads mem_writes
# words repeat over the 8 words of a line; counts are memory operations of that access
read  00000100 00000000 00000000 00000100 1 0
read  00000104 00000000 00000000 00000100 0 0
write 00000100 33333333 aabbccdd 00000100 0 0
read  00000100 00000000 00000000 0000ccdd 0 0
read  00000020 00000000 00000000 00000020 1 0
read  00000120 00000000 00000000 00000120 1 0
read  00000020 00000000 00000000 00000020 0 0
read  00000220 00000000 00000000 00000220 1 0
read  00000020 00000000 00000000 00000020 0 0
read  00000120 00000000 00000000 00000120 1 0
read  00000200 00000000 00000000 00000200 1 0
read  00000300 00000000 00000000 00000300 1 1
read  00000100 00000000 00000000 0000ccdd 1 0
write 00000340 ffffffff 12345678 00000340 1 0
read  00000340 00000000 00000000 12345678 0 0
read  00000040 00000000 00000000 00000040 1 0
read  00000140 00000000 00000000 00000140 1 1
read  00000340 00000000 00000000 12345678 1 0

//--- verif/tb_cache_top.sv
// testbench for the two-way L1 cache, driven from a pattern file
`timescale 1ns/1ps

module tb_cache_top;

    localparam int max_wait_cycles = 200;

    logic clk;
    logic reset;
    logic cpu_valid;
    logic cpu_write;
    logic [31:0] cpu_address;
    cache_pkg::mask_t cpu_byte_enable;
    cache_pkg::line_t cpu_wdata;
    logic cpu_ready;
    cache_pkg::line_t cpu_rdata;
    logic pmem_valid;
    logic pmem_write;
    logic [31:0] pmem_address;
    cache_pkg::line_t pmem_wdata;
    cache_pkg::line_t pmem_rdata;
    logic pmem_ready;
    int read_count;
    int write_count;
    int op_count;

    cache_top i_cache_top (
        .clk(clk),
        .reset(reset),
        .cpu_valid(cpu_valid),
        .cpu_write(cpu_write),
        .cpu_address(cpu_address),
        .cpu_byte_enable(cpu_byte_enable),
        .cpu_wdata(cpu_wdata),
        .cpu_ready(cpu_ready),
        .cpu_rdata(cpu_rdata),
        .pmem_valid(pmem_valid),
        .pmem_write(pmem_write),
        .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata),
        .pmem_rdata(pmem_rdata),
        .pmem_ready(pmem_ready)
    );

    pmem_model i_pmem_model (
        .clk(clk),
        .reset(reset),
        .pmem_valid(pmem_valid),
        .pmem_write(pmem_write),
        .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata),
        .pmem_rdata(pmem_rdata),
        .pmem_ready(pmem_ready),
        .read_count(read_count),
        .write_count(write_count)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10;
            clk = ~clk;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] actual,
        input logic [255:0] expected);
        if (actual !== expected)
        begin
            fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    task automatic run_op(input logic is_write, input logic [31:0] address,
        input cache_pkg::mask_t mask, input logic [31:0] wdata_word,
        input logic [31:0] expected_word, input int expected_reads, input int expected_writes);
        int reads_before;
        int writes_before;
        int waited;
        logic seen;

        @(negedge clk);
        // ready lasts a single cycle
        check_value("cpu_ready", {255'b0, cpu_ready}, 256'b0);
        reads_before = read_count;
        writes_before = write_count;
        cpu_valid = 1'b1;
        cpu_write = is_write;
        cpu_address = address;
        cpu_byte_enable = mask;
        cpu_wdata = {8{wdata_word}};

        waited = 0;
        seen = 1'b0;
        while (!seen && waited < max_wait_cycles)
        begin
            @(negedge clk);
            if (cpu_ready)
            begin
                seen = 1'b1;
            end
            else
            begin
                waited++;
            end
        end
        if (!seen)
        begin
            fail_run($sformatf("cpu_ready did not rise within %0d cycles for address %h",
                max_wait_cycles, address));
        end

        check_value("cpu_rdata", cpu_rdata, {8{expected_word}});
        check_value("pmem reads", 256'(read_count - reads_before), 256'(expected_reads));
        check_value("pmem writes", 256'(write_count - writes_before), 256'(expected_writes));
        // a hit answers one cycle after compare
        if (expected_reads == 0 && expected_writes == 0)
        begin
            check_value("hit latency", 256'(waited), 256'(1));
        end

        // transfer edge
        @(posedge clk);
    endtask

    initial
    begin
        int fd;
        int fields;
        logic [8*128-1:0] line_text;
        logic [8*5-1:0] op_text;
        logic [31:0] address;
        logic [31:0] mask;
        logic [31:0] wdata_word;
        logic [31:0] expected_word;
        int expected_reads;
        int expected_writes;

        reset = 1'b1;
        cpu_valid = 1'b0;
        cpu_write = 1'b0;
        cpu_address = '0;
        cpu_byte_enable = '0;
        cpu_wdata = '0;
        op_count = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen("verif/cache_patterns.txt", "r");
        if (fd == 0)
        begin
            fail_run("could not open verif/cache_patterns.txt");
        end
        while ($fgets(line_text, fd) != 0)
        begin
            // comment and blank lines do not yield seven fields
            fields = $sscanf(line_text, "%s %h %h %h %h %d %d", op_text, address, mask,
                wdata_word, expected_word, expected_reads, expected_writes);
            if (fields == 7)
            begin
                run_op(op_text == "write", address, mask, wdata_word, expected_word,
                    expected_reads, expected_writes);
                op_count++;
            end
        end
        $fclose(fd);

        @(negedge clk);
        cpu_valid = 1'b0;
        cpu_write = 1'b0;

        if (op_count > 0)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
        begin
            fail_run("the pattern file held no operations");
        end
    end

endmodule

//--- verif/pmem_model.sv
// line-addressed memory model with random ready delay and operation counters
`timescale 1ns/1ps

module pmem_model
(
    input logic clk,
    input logic reset,
    input logic pmem_valid,
    input logic pmem_write,
    input logic [31:0] pmem_address,
    input cache_pkg::line_t pmem_wdata,
    output cache_pkg::line_t pmem_rdata,
    output logic pmem_ready,
    output int read_count,
    output int write_count
);

    localparam int line_number_bits = 32 - cache_pkg::offset_bits;

    logic [15:0] lfsr_state;
    logic [1:0] delay_bits;
    logic busy;
    int wait_left;
    cache_pkg::line_t mem [logic [line_number_bits-1:0]];

    // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0])
        begin
            return (state >> 1) ^ 16'hb400;
        end
        return state >> 1;
    endfunction

    // untouched lines hold their own line address in every word
    function automatic cache_pkg::line_t line_value(input logic [line_number_bits-1:0] number);
        if (mem.exists(number) != 0)
        begin
            return mem[number];
        end
        return {8{number, {cache_pkg::offset_bits{1'b0}}}};
    endfunction

    initial
    begin
        lfsr_state = 16'd10;
        pmem_ready = 1'b0;
        pmem_rdata = '0;
        busy = 1'b0;
        wait_left = 0;
        read_count = 0;
        write_count = 0;
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            pmem_ready <= 1'b0;
            busy <= 1'b0;
            wait_left <= 0;
            read_count <= 0;
            write_count <= 0;
        end
        else if (pmem_ready)
        begin
            pmem_ready <= 1'b0;
            busy <= 1'b0;
        end
        else if (pmem_valid && !busy)
        begin
            // one lfsr step per delay bit
            delay_bits[0] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
            delay_bits[1] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
            busy <= 1'b1;
            wait_left <= int'(delay_bits);
        end
        else if (pmem_valid && wait_left == 0)
        begin
            pmem_ready <= 1'b1;
            if (pmem_write)
            begin
                mem[pmem_address[31:cache_pkg::offset_bits]] = pmem_wdata;
                write_count <= write_count + 1;
            end
            else
            begin
                pmem_rdata <= line_value(pmem_address[31:cache_pkg::offset_bits]);
                read_count <= read_count + 1;
            end
        end
        else if (pmem_valid)
        begin
            wait_left <= wait_left - 1;
        end
    end

endmodule

//--- source/cache_top.sv
// two-way write-back L1 cache joining the controller and the datapath
`timescale 1ns/1ps

module cache_top #(
    parameter int offset_bits = cache_pkg::offset_bits,
    parameter int index_bits = cache_pkg::index_bits
)
(
    input logic clk,
    input logic reset,
    input logic cpu_valid,
    input logic cpu_write,
    input logic [31:0] cpu_address,
    input cache_pkg::mask_t cpu_byte_enable,
    input cache_pkg::line_t cpu_wdata,
    output logic cpu_ready,
    output cache_pkg::line_t cpu_rdata,
    output logic pmem_valid,
    output logic pmem_write,
    output logic [31:0] pmem_address,
    output cache_pkg::line_t pmem_wdata,
    input cache_pkg::line_t pmem_rdata,
    input logic pmem_ready
);

    logic hit;
    logic victim_dirty;
    logic load_tag;
    logic set_valid;
    logic set_dirty;
    logic clear_dirty;
    logic load_data;
    logic fill_select;
    logic touch_lru;
    logic wb_select;

    cache_control i_control (
        .clk(clk),
        .reset(reset),
        .cpu_valid(cpu_valid),
        .cpu_write(cpu_write),
        .hit(hit),
        .victim_dirty(victim_dirty),
        .pmem_ready(pmem_ready),
        .cpu_ready(cpu_ready),
        .pmem_valid(pmem_valid),
        .pmem_write(pmem_write),
        .load_tag(load_tag),
        .set_valid(set_valid),
        .set_dirty(set_dirty),
        .clear_dirty(clear_dirty),
        .load_data(load_data),
        .fill_select(fill_select),
        .touch_lru(touch_lru),
        .wb_select(wb_select)
    );

    cache_datapath #(.offset_bits(offset_bits), .index_bits(index_bits)) i_datapath (
        .clk(clk),
        .reset(reset),
        .cpu_address(cpu_address),
        .cpu_byte_enable(cpu_byte_enable),
        .cpu_wdata(cpu_wdata),
        .pmem_rdata(pmem_rdata),
        .load_tag(load_tag),
        .set_valid(set_valid),
        .set_dirty(set_dirty),
        .clear_dirty(clear_dirty),
        .load_data(load_data),
        .fill_select(fill_select),
        .touch_lru(touch_lru),
        .wb_select(wb_select),
        .hit(hit),
        .victim_dirty(victim_dirty),
        .cpu_rdata(cpu_rdata),
        .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata)
    );

endmodule

//--- source/cache_control.sv
// cache controller FSM for lookup, writeback, fill and CPU response
`timescale 1ns/1ps

module cache_control
(
    input logic clk,
    input logic reset,
    input logic cpu_valid,
    input logic cpu_write,
    input logic hit,
    input logic victim_dirty,
    input logic pmem_ready,
    output logic cpu_ready,
    output logic pmem_valid,
    output logic pmem_write,
    output logic load_tag,
    output logic set_valid,
    output logic set_dirty,
    output logic clear_dirty,
    output logic load_data,
    output logic fill_select,
    output logic touch_lru,
    output logic wb_select
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= cache_pkg::idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        cpu_ready = 1'b0;
        pmem_valid = 1'b0;
        pmem_write = 1'b0;
        load_tag = 1'b0;
        set_valid = 1'b0;
        set_dirty = 1'b0;
        clear_dirty = 1'b0;
        load_data = 1'b0;
        fill_select = 1'b0;
        touch_lru = 1'b0;
        wb_select = 1'b0;

        case (state)
            cache_pkg::idle:
            begin
                if (cpu_valid)
                begin
                    next_state = cache_pkg::compare;
                end
            end
            cache_pkg::compare:
            begin
                if (hit)
                begin
                    // merge a write into the hit line
                    load_data = cpu_write;
                    set_dirty = cpu_write;
                    touch_lru = 1'b1;
                    next_state = cache_pkg::respond;
                end
                else if (victim_dirty)
                begin
                    next_state = cache_pkg::writeback;
                end
                else
                begin
                    next_state = cache_pkg::fill;
                end
            end
            cache_pkg::writeback:
            begin
                pmem_valid = 1'b1;
                pmem_write = 1'b1;
                wb_select = 1'b1;
                if (pmem_ready)
                begin
                    next_state = cache_pkg::fill;
                end
            end
            cache_pkg::fill:
            begin
                pmem_valid = 1'b1;
                fill_select = 1'b1;
                if (pmem_ready)
                begin
                    load_data = 1'b1;
                    load_tag = 1'b1;
                    set_valid = 1'b1;
                    clear_dirty = 1'b1;
                    // retire through compare as a hit
                    next_state = cache_pkg::compare;
                end
            end
            cache_pkg::respond:
            begin
                cpu_ready = 1'b1;
                next_state = cache_pkg::idle;
            end
            default:
            begin
                next_state = cache_pkg::idle;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (reset)
        (pmem_valid && !pmem_ready) |=> pmem_valid)
        else $error("pmem_valid dropped before pmem_ready");

endmodule

//--- source/cache_datapath.sv
// two-way cache datapath with tag compare, way select, write masks and LRU
`timescale 1ns/1ps

module cache_datapath #(
    parameter int offset_bits = 5,
    parameter int index_bits = 3
)
(
    input logic clk,
    input logic reset,
    input logic [31:0] cpu_address,
    input cache_pkg::mask_t cpu_byte_enable,
    input cache_pkg::line_t cpu_wdata,
    input cache_pkg::line_t pmem_rdata,
    input logic load_tag,
    input logic set_valid,
    input logic set_dirty,
    input logic clear_dirty,
    input logic load_data,
    input logic fill_select,
    input logic touch_lru,
    input logic wb_select,
    output logic hit,
    output logic victim_dirty,
    output cache_pkg::line_t cpu_rdata,
    output logic [31:0] pmem_address,
    output cache_pkg::line_t pmem_wdata
);

    logic [index_bits-1:0] index;
    cache_pkg::tag_t cpu_tag;
    cache_pkg::tag_t way_tag [2];
    logic way_valid [2];
    logic way_dirty [2];
    logic way_hit [2];
    cache_pkg::line_t way_line [2];
    cache_pkg::mask_t way_mask [2];
    logic lru;
    logic way_sel;
    cache_pkg::mask_t write_mask;
    cache_pkg::line_t write_data;
    cache_pkg::line_t rdata_q;

    assign index = cpu_address[offset_bits +: index_bits];
    assign cpu_tag = cache_pkg::tag_t'(cpu_address >> (offset_bits + index_bits));

    assign hit = way_hit[0] || way_hit[1];

    // hit way when there is one, else the LRU victim
    assign way_sel = hit ? way_hit[1] : lru;
    assign victim_dirty = way_dirty[lru];

    assign write_mask = fill_select ? '1 : cpu_byte_enable;
    assign write_data = fill_select ? pmem_rdata : cpu_wdata;

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        logic selected;

        assign selected = (way_sel == 1'(w));
        assign way_hit[w] = way_valid[w] && (way_tag[w] == cpu_tag);
        assign way_mask[w] = (load_data && selected) ? write_mask : '0;

        cache_array #(.index_bits(index_bits), .entry_t(cache_pkg::tag_t)) i_tag (
            .clk(clk),
            .reset(reset),
            .load(load_tag && selected),
            .index(index),
            .datain(cpu_tag),
            .dataout(way_tag[w])
        );

        cache_array #(.index_bits(index_bits), .entry_t(logic)) i_valid (
            .clk(clk),
            .reset(reset),
            .load(set_valid && selected),
            .index(index),
            .datain(1'b1),
            .dataout(way_valid[w])
        );

        cache_array #(.index_bits(index_bits), .entry_t(logic)) i_dirty (
            .clk(clk),
            .reset(reset),
            .load((set_dirty || clear_dirty) && selected),
            .index(index),
            .datain(set_dirty),
            .dataout(way_dirty[w])
        );

        cache_data_array #(.index_bits(index_bits)) i_data (
            .clk(clk),
            .write_mask(way_mask[w]),
            .index(index),
            .datain(write_data),
            .dataout(way_line[w])
        );
    end

    // lru bit names the next victim, so point it away from the used way
    cache_array #(.index_bits(index_bits), .entry_t(logic)) i_lru (
        .clk(clk),
        .reset(reset),
        .load(touch_lru),
        .index(index),
        .datain(!way_sel),
        .dataout(lru)
    );

    // line as it stood before any write merge
    always_ff @(posedge clk)
    begin
        if (touch_lru)
        begin
            rdata_q <= way_line[way_sel];
        end
    end

    assign cpu_rdata = rdata_q;
    assign pmem_wdata = way_line[lru];

    assign pmem_address = wb_select
        ? ((32'(way_tag[lru]) << (offset_bits + index_bits)) | (32'(index) << offset_bits))
        : {cpu_address[31:offset_bits], {offset_bits{1'b0}}};

    // a line never sits in both ways when data is written
    assert property (@(posedge clk) disable iff (reset)
        load_data |-> !(way_hit[0] && way_hit[1]))
        else $error("load_data with the tag present in both ways");

    // a CPU write is only merged into a line that is present
    assert property (@(posedge clk) disable iff (reset)
        (load_data && !fill_select) |-> hit)
        else $error("CPU write merged on a miss");

endmodule

//--- source/cache_data_array.sv
// line storage for one way with a byte-granular write mask
`timescale 1ns/1ps

module cache_data_array #(
    parameter int index_bits = 3
)
(
    input logic clk,
    input cache_pkg::mask_t write_mask,
    input logic [index_bits-1:0] index,
    input cache_pkg::line_t datain,
    output cache_pkg::line_t dataout
);

    localparam int num_sets = 2 ** index_bits;

    cache_pkg::line_t lines [num_sets];

    // one byte lane per mask bit
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < cache_pkg::mask_bits; i++)
        begin
            if (write_mask[i])
            begin
                lines[index][8*i +: 8] <= datain[8*i +: 8];
            end
        end
    end

    assign dataout = lines[index];

endmodule

//--- source/cache_array.sv
// per-set state storage with one write port and combinational read
`timescale 1ns/1ps

module cache_array #(
    parameter int index_bits = 3,
    parameter type entry_t = logic
)
(
    input logic clk,
    input logic reset,
    input logic load,
    input logic [index_bits-1:0] index,
    input entry_t datain,
    output entry_t dataout
);

    localparam int num_sets = 2 ** index_bits;

    entry_t entries [num_sets];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < num_sets; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (load)
        begin
            entries[index] <= datain;
        end
    end

    assign dataout = entries[index];

    // every set was cleared, so a known index gives a known entry
    assert property (@(posedge clk) disable iff (reset)
        !$isunknown(index) |-> !$isunknown(dataout))
        else $error("cache_array read an unknown entry after reset");

endmodule

//--- source/cache_pkg.sv
// geometry, payload types and controller states for the two-way L1 cache
package cache_pkg;

    // byte offset within a 32-byte line
    localparam int offset_bits = 5;
    // 8 sets
    localparam int index_bits = 3;
    localparam int tag_bits = 32 - index_bits - offset_bits;

    localparam int line_bits = 8 * (2 ** offset_bits);
    localparam int mask_bits = line_bits / 8;

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [line_bits-1:0] line_t;
    typedef logic [mask_bits-1:0] mask_t;

    typedef enum logic [2:0] {
        idle,
        compare,
        writeback,
        fill,
        respond
    } ctrl_state_t;

endpackage
